//--- cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    typedef logic [31:0] word_t;     // Data, address or instruction word
    typedef logic [4:0]  reg_addr_t; // Register index

    // Primary opcodes, instr[31:26]
    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_JUMP  = 6'h02;
    localparam logic [5:0] OP_ADDI  = 6'h08;
    localparam logic [5:0] OP_ORI   = 6'h0d;
    localparam logic [5:0] OP_LUI   = 6'h0f;
    localparam logic [5:0] OP_LDB   = 6'h24; // Zero-extended byte
    localparam logic [5:0] OP_LDW   = 6'h23;
    localparam logic [5:0] OP_STB   = 6'h28;
    localparam logic [5:0] OP_STW   = 6'h2b;
    localparam logic [5:0] OP_HALT  = 6'h3f;

    // R-type function codes, instr[5:0]
    localparam logic [5:0] FN_MUL = 6'h18; // Low 32 bits of product
    localparam logic [5:0] FN_ADD = 6'h20;
    localparam logic [5:0] FN_SUB = 6'h22;
    localparam logic [5:0] FN_AND = 6'h24;
    localparam logic [5:0] FN_OR  = 6'h25;
    localparam logic [5:0] FN_SLT = 6'h2a;

    typedef struct packed {
        logic regwrite; // WB: write dest_reg
        logic memtoreg; // WB: take load data
        logic memwrite; // MEM: store
        logic memread;  // MEM: load
        logic byteword; // MEM: 1 word, 0 byte
        logic alusrc;   // EX: second operand is imm
        logic is_mult;  // EX: multiply
    } ctrl_t;

    typedef struct packed {
        logic       valid;
        word_t      pc;
        logic [5:0] op_code;
        logic [5:0] funct_code;
        word_t      op_a;     // rs value
        word_t      op_b;     // rt value
        word_t      imm;      // Already extended
        reg_addr_t  dest_reg;
        ctrl_t      ctrl;
    } id_ex_t;

    typedef struct packed {
        logic      valid;
        word_t     result;     // ALU result or byte address
        word_t     store_data;
        reg_addr_t dest_reg;
        ctrl_t     ctrl;
        logic      halt;
    } ex_mem_t;

    typedef struct packed {
        logic      valid;
        reg_addr_t dest_reg;
        logic      regwrite;
        word_t     data;
    } mem_wb_t;

    typedef struct packed {
        logic       valid;
        logic       we;
        word_t      addr;  // Word index, not byte address
        word_t      wdata;
        logic [3:0] be;
    } mem_req_t;

    typedef enum logic [1:0] {
        FETCH_IDLE,
        FETCH_RUN,
        FETCH_HALT
    } fetch_state_t;

endpackage

`default_nettype wire

//--- fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit import cpu_pkg::*; (
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire logic     run,
    input  wire logic     grant,
    input  wire word_t    mem_rdata,
    input  wire word_t    jump_addr,
    input  wire logic     is_jump,
    input  wire logic     is_halt,
    output mem_req_t      req,
    output word_t         instr,
    output word_t         instr_pc,
    output logic          instr_valid
);

    fetch_state_t state;
    word_t        pc;
    word_t        pend_addr;  // Jump target waiting for the delay slot grant
    logic         pend_jump;
    logic         pend_halt;
    logic         granted_q;  // Word on mem_rdata is ours this cycle
    logic         redirect;
    word_t        target;

    assign redirect = is_jump | pend_jump;
    assign target   = is_jump ? jump_addr : pend_addr;

    // Read-only requests, one per cycle while running
    assign req = '{valid: (state == FETCH_RUN) && run, we: 1'b0,
                   addr: {2'b00, pc[31:2]}, wdata: '0, be: 4'hf};

    assign instr       = mem_rdata;
    assign instr_valid = granted_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= FETCH_IDLE;
            pc        <= '0;
            pend_jump <= 1'b0;
            pend_halt <= 1'b0;
            granted_q <= 1'b0;
        end else begin
            granted_q <= grant && req.valid;
            if (state == FETCH_IDLE && run) state <= FETCH_RUN;
            if (grant && req.valid) begin
                instr_pc  <= pc;                         // Tag for decode
                pc        <= redirect ? target : pc + 32'd4; // Delay slot just went out
                pend_jump <= 1'b0;
                if (is_halt || pend_halt) state <= FETCH_HALT;
                pend_halt <= 1'b0;
            end else begin
                if (is_jump) begin
                    pend_jump <= 1'b1;
                    pend_addr <= jump_addr;
                end
                if (is_halt) pend_halt <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- decode_control.sv
`timescale 1ns/1ps
`default_nettype none

module decode_control import cpu_pkg::*; (
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire logic [5:0] op_code,
    input  wire logic [5:0] funct_code,
    input  wire logic       instr_valid,
    output ctrl_t           ctrl
);

    ctrl_t next;

    always_comb begin
        next = '0;
        case (op_code)
            OP_RTYPE: begin
                next.regwrite = 1'b1;
                next.is_mult  = (funct_code == FN_MUL);
            end
            OP_ADDI, OP_ORI, OP_LUI: begin
                next.regwrite = 1'b1;
                next.alusrc   = 1'b1;
            end
            OP_LDW, OP_LDB: begin
                next.regwrite = 1'b1;
                next.memtoreg = 1'b1;
                next.memread  = 1'b1;
                next.alusrc   = 1'b1;                 // Base plus offset
                next.byteword = (op_code == OP_LDW);
            end
            OP_STW, OP_STB: begin
                next.memwrite = 1'b1;
                next.alusrc   = 1'b1;
                next.byteword = (op_code == OP_STW);
            end
            default: next = '0; // Jump and halt touch no state here
        endcase
    end

    // Registered on the decode boundary, same rule as the stage register
    always_ff @(posedge clk) begin
        if (rst) begin
            ctrl <= '0;
        end else if (instr_valid) begin
            ctrl <= next;
        end else begin
            ctrl.regwrite <= 1'b0; // Bubble must not write anything
            ctrl.memwrite <= 1'b0;
            ctrl.memread  <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage import cpu_pkg::*; (
    input  wire logic  clk,
    input  wire logic  rst,
    input  wire word_t instr,
    input  wire word_t instr_pc,
    input  wire logic  instr_valid,
    input  wire word_t rd_data1,
    input  wire word_t rd_data2,
    output reg_addr_t  src_reg1,
    output reg_addr_t  src_reg2,
    output word_t      jump_addr,
    output logic       is_jump,
    output logic       is_halt,
    output id_ex_t     id_ex
);

    logic [5:0] opcode;
    logic [5:0] functcode;
    logic [15:0] imm16;
    reg_addr_t  dst;
    word_t      imm_ext;
    ctrl_t      ctrl;

    // Stage register, ctrl lives in decode_control
    logic       valid_q;
    word_t      pc_q;
    logic [5:0] op_q;
    logic [5:0] fn_q;
    word_t      a_q;
    word_t      b_q;
    word_t      imm_q;
    reg_addr_t  dest_q;

    assign opcode    = instr[31:26];
    assign functcode = instr[5:0];
    assign imm16     = instr[15:0];
    assign src_reg1  = instr[25:21]; // rs
    assign src_reg2  = instr[20:16]; // rt

    // Toward fetch, no clock involved
    assign jump_addr = {instr_pc[31:28], instr[25:0], 2'b00};
    assign is_jump   = instr_valid && (opcode == OP_JUMP);
    assign is_halt   = instr_valid && (opcode == OP_HALT);

    always_comb begin
        case (opcode)
            OP_STW, OP_STB:                         dst = '0;          // Stores write nothing
            OP_ADDI, OP_ORI, OP_LUI, OP_LDW, OP_LDB: dst = instr[20:16]; // rt
            default:                                dst = instr[15:11]; // rd
        endcase
        case (opcode)
            OP_ORI:  imm_ext = {16'h0000, imm16};
            OP_LUI:  imm_ext = {imm16, 16'h0000};
            default: imm_ext = {{16{imm16[15]}}, imm16};
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= instr_valid; // Bubble clears valid only
        end
        if (instr_valid) begin
            pc_q   <= instr_pc;
            op_q   <= opcode;
            fn_q   <= functcode;
            a_q    <= rd_data1;
            b_q    <= rd_data2;
            imm_q  <= imm_ext;
            dest_q <= dst;
        end
    end

    decode_control u_control (
        .clk        (clk),
        .rst        (rst),
        .op_code    (opcode),
        .funct_code (functcode),
        .instr_valid(instr_valid),
        .ctrl       (ctrl)
    );

    assign id_ex = '{valid: valid_q, pc: pc_q, op_code: op_q, funct_code: fn_q,
                     op_a: a_q, op_b: b_q, imm: imm_q, dest_reg: dest_q, ctrl: ctrl};

endmodule

`default_nettype wire

//--- register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file import cpu_pkg::*; (
    input  wire logic      clk,
    input  wire logic      rst,
    input  wire reg_addr_t rd_addr1,
    input  wire reg_addr_t rd_addr2,
    input  wire mem_wb_t   wb,
    output word_t          rd_data1,
    output word_t          rd_data2
);

    word_t regs [32];
    logic  wr_en;

    assign wr_en = wb.valid && wb.regwrite && (wb.dest_reg != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) regs[i] <= '0;
        end else if (wr_en) begin
            regs[wb.dest_reg] <= wb.data;
        end
    end

    // r0 reads zero, same-cycle write passes straight through
    assign rd_data1 = (rd_addr1 == '0) ? '0 :
                      (wr_en && wb.dest_reg == rd_addr1) ? wb.data : regs[rd_addr1];
    assign rd_data2 = (rd_addr2 == '0) ? '0 :
                      (wr_en && wb.dest_reg == rd_addr2) ? wb.data : regs[rd_addr2];

endmodule

`default_nettype wire

//--- execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage import cpu_pkg::*; (
    input  wire logic   clk,
    input  wire logic   rst,
    input  wire id_ex_t id_ex,
    output ex_mem_t     ex_mem
);

    word_t a;
    word_t b;
    word_t product;
    word_t result;

    assign a       = id_ex.op_a;
    assign b       = id_ex.ctrl.alusrc ? id_ex.imm : id_ex.op_b;
    assign product = a * b; // Low half only

    always_comb begin
        case (id_ex.op_code)
            OP_RTYPE: begin
                if (id_ex.ctrl.is_mult) begin
                    result = product;
                end else begin
                    case (id_ex.funct_code)
                        FN_SUB:  result = a - b;
                        FN_AND:  result = a & b;
                        FN_OR:   result = a | b;
                        FN_SLT:  result = {31'b0, $signed(a) < $signed(b)};
                        default: result = a + b; // FN_ADD
                    endcase
                end
            end
            OP_ORI:  result = a | b;
            OP_LUI:  result = b;     // Imm already in the upper half
            default: result = a + b; // addi, load and store address
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_mem.valid <= 1'b0;
        end else begin
            ex_mem.valid <= id_ex.valid;
        end
        ex_mem.result     <= result;
        ex_mem.store_data <= id_ex.op_b;   // rt value, never the imm
        ex_mem.dest_reg   <= id_ex.dest_reg;
        ex_mem.ctrl       <= id_ex.ctrl;
        ex_mem.halt       <= id_ex.valid && (id_ex.op_code == OP_HALT);
    end

endmodule

`default_nettype wire

//--- mem_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mem_stage import cpu_pkg::*; (
    input  wire logic    clk,
    input  wire logic    rst,
    input  wire ex_mem_t ex_mem,
    input  wire word_t   mem_rdata,
    output mem_req_t     req,
    output mem_wb_t      wb,
    output logic         halt_retire
);

    logic [1:0] lane;
    logic [1:0] lane_q;   // Byte lane of the pending load
    logic       byte_q;   // Pending load is a byte load
    logic       memtoreg_q;
    logic       valid_q;
    reg_addr_t  dest_q;
    logic       regwrite_q;
    word_t      result_q;
    word_t      load_data;

    assign lane = ex_mem.result[1:0];

    // Byte store goes out on every lane and the enable picks one
    assign req = '{valid: ex_mem.valid && (ex_mem.ctrl.memwrite || ex_mem.ctrl.memread),
                   we:    ex_mem.ctrl.memwrite,
                   addr:  {2'b00, ex_mem.result[31:2]},
                   wdata: ex_mem.ctrl.byteword ? ex_mem.store_data
                                               : {4{ex_mem.store_data[7:0]}},
                   be:    ex_mem.ctrl.byteword ? 4'hf : (4'b0001 << lane)};

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q     <= 1'b0;
            halt_retire <= 1'b0;
        end else begin
            // Only real register writes count as writebacks
            valid_q <= ex_mem.valid && ex_mem.ctrl.regwrite && (ex_mem.dest_reg != '0);
            if (ex_mem.valid && ex_mem.halt) halt_retire <= 1'b1; // Sticky
        end
        dest_q     <= ex_mem.dest_reg;
        regwrite_q <= ex_mem.ctrl.regwrite;
        result_q   <= ex_mem.result;
        memtoreg_q <= ex_mem.ctrl.memtoreg;
        byte_q     <= !ex_mem.ctrl.byteword;
        lane_q     <= lane;
    end

    // Read data arrives the cycle after the request
    assign load_data = byte_q ? {24'h0, mem_rdata[8*lane_q +: 8]} : mem_rdata;
    assign wb = '{valid: valid_q, dest_reg: dest_q, regwrite: regwrite_q,
                  data: memtoreg_q ? load_data : result_q};

endmodule

`default_nettype wire

//--- mem_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter import cpu_pkg::*; (
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire mem_req_t host_req_i,
    input  wire mem_req_t data_req,
    input  wire mem_req_t fetch_req,
    input  wire word_t    ram_rdata,
    output logic          host_grant,
    output logic          data_grant,
    output logic          fetch_grant,
    output mem_req_t      ram_req,
    output word_t         rdata,
    output logic          host_ack
);

    logic [2:0] owner_q; // One-hot {host, data, fetch} of last cycle's grant

    // Host first, then data, fetch last
    assign host_grant  = host_req_i.valid;
    assign data_grant  = data_req.valid && !host_grant;
    assign fetch_grant = fetch_req.valid && !host_grant && !data_req.valid;

    always_comb begin
        if (host_grant)       ram_req = host_req_i;
        else if (data_grant)  ram_req = data_req;
        else if (fetch_grant) ram_req = fetch_req;
        else                  ram_req = '0; // Idle, valid low
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            owner_q <= '0;
        end else begin
            owner_q <= {host_grant, data_grant, fetch_grant};
        end
    end

    // Read data only while some requester owns the return slot
    assign rdata    = (|owner_q) ? ram_rdata : '0;
    assign host_ack = owner_q[2];

endmodule

`default_nettype wire

//--- unified_mem.sv
`timescale 1ns/1ps
`default_nettype none

module unified_mem import cpu_pkg::*; #(
    parameter int MEM_WORDS = 1024
) (
    input  wire logic     clk,
    input  wire mem_req_t ram_req,
    output word_t         ram_rdata
);

    localparam int AW = $clog2(MEM_WORDS);

    word_t          mem [MEM_WORDS];
    logic [AW-1:0]  idx;

    assign idx = ram_req.addr[AW-1:0]; // Wraps modulo MEM_WORDS

    always_ff @(posedge clk) begin
        if (ram_req.valid && ram_req.we) begin
            for (int i = 0; i < 4; i++) begin
                if (ram_req.be[i]) mem[idx][8*i +: 8] <= ram_req.wdata[8*i +: 8];
            end
        end
        if (ram_req.valid && !ram_req.we) begin
            ram_rdata <= mem[idx]; // One-cycle read
        end
    end

endmodule

`default_nettype wire

//--- cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_top import cpu_pkg::*; #(
    parameter int MEM_WORDS = 1024
) (
    input  wire logic      clk,
    input  wire logic      rst,
    input  wire logic      run,
    input  wire logic      host_req,    // Strobe
    input  wire logic      host_we,
    input  wire word_t     host_addr,   // Word index
    input  wire word_t     host_wdata,
    output word_t          host_rdata,
    output logic           host_ack,
    output logic           wb_valid,
    output reg_addr_t      wb_reg,
    output word_t          wb_data,
    output logic           halted
);

    mem_req_t  host_mreq, fetch_req, data_req, ram_req;
    logic      data_grant, fetch_grant;
    word_t     mem_rdata, ram_rdata;
    word_t     instr, instr_pc, jump_addr;
    logic      instr_valid, is_jump, is_halt;
    reg_addr_t src_reg1, src_reg2;
    word_t     rd_data1, rd_data2;
    id_ex_t    id_ex;
    ex_mem_t   ex_mem;
    mem_wb_t   wb;

    // Host port as a full-word request
    assign host_mreq = '{valid: host_req, we: host_we, addr: host_addr,
                         wdata: host_wdata, be: 4'hf};
    assign host_rdata = mem_rdata;
    assign wb_valid   = wb.valid;
    assign wb_reg     = wb.dest_reg;
    assign wb_data    = wb.data;

    fetch_unit u_fetch (
        .clk(clk), .rst(rst), .run(run), .grant(fetch_grant), .mem_rdata(mem_rdata),
        .jump_addr(jump_addr), .is_jump(is_jump), .is_halt(is_halt),
        .req(fetch_req), .instr(instr), .instr_pc(instr_pc), .instr_valid(instr_valid)
    );

    decode_stage u_decode (
        .clk(clk), .rst(rst), .instr(instr), .instr_pc(instr_pc),
        .instr_valid(instr_valid), .rd_data1(rd_data1), .rd_data2(rd_data2),
        .src_reg1(src_reg1), .src_reg2(src_reg2), .jump_addr(jump_addr),
        .is_jump(is_jump), .is_halt(is_halt), .id_ex(id_ex)
    );

    register_file u_regs (
        .clk(clk), .rst(rst), .rd_addr1(src_reg1), .rd_addr2(src_reg2), .wb(wb),
        .rd_data1(rd_data1), .rd_data2(rd_data2)
    );

    execute_stage u_execute (.clk(clk), .rst(rst), .id_ex(id_ex), .ex_mem(ex_mem));

    mem_stage u_mem (
        .clk(clk), .rst(rst), .ex_mem(ex_mem), .mem_rdata(mem_rdata),
        .req(data_req), .wb(wb), .halt_retire(halted)
    );

    mem_arbiter u_arb (
        .clk(clk), .rst(rst), .host_req_i(host_mreq), .data_req(data_req),
        .fetch_req(fetch_req), .ram_rdata(ram_rdata), .host_grant(),
        .data_grant(data_grant), .fetch_grant(fetch_grant), .ram_req(ram_req),
        .rdata(mem_rdata), .host_ack(host_ack)
    );

    unified_mem #(.MEM_WORDS(MEM_WORDS)) u_ram (
        .clk(clk), .ram_req(ram_req), .ram_rdata(ram_rdata)
    );

endmodule

`default_nettype wire

//--- cpu_assert.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_assert (
    input wire logic       clk,
    input wire logic       rst,
    input wire logic       host_grant,
    input wire logic       data_grant,
    input wire logic       fetch_grant,
    input wire logic       host_ack,
    input wire logic       wb_valid,
    input wire logic [4:0] wb_dest
);

    // One owner for the single memory port
    one_grant: assert property (@(posedge clk) disable iff (rst)
        $onehot0({host_grant, data_grant, fetch_grant}))
        else $error("more than one grant in a cycle");

    ack_after_grant: assert property (@(posedge clk) disable iff (rst)
        host_ack |-> $past(host_grant))
        else $error("host_ack without a host grant one cycle earlier");

    no_r0_retire: assert property (@(posedge clk) disable iff (rst)
        wb_valid |-> (wb_dest != 5'd0))
        else $error("writeback to register 0");

endmodule

// Arbiter side with the writeback inputs tied off
bind mem_arbiter cpu_assert arb_checks (
    .clk(clk), .rst(rst), .host_grant(host_grant), .data_grant(data_grant),
    .fetch_grant(fetch_grant), .host_ack(host_ack), .wb_valid(1'b0), .wb_dest(5'd0)
);

bind mem_stage cpu_assert wb_checks (
    .clk(clk), .rst(rst), .host_grant(1'b0), .data_grant(1'b0), .fetch_grant(1'b0),
    .host_ack(1'b0), .wb_valid(wb.valid), .wb_dest(wb.dest_reg)
);

`default_nettype wire

//--- cpu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_tb import cpu_pkg::*; ();

    localparam int CLK_PERIOD = 20;
    localparam int MEM_WORDS  = 1024;
    localparam int N_SLOTS    = 60;              // Program instructions before halt
    localparam int PROG_WORDS = 4 * N_SLOTS + 4; // Each slot is one instr plus three nops
    localparam int DATA_BASE  = 512;             // Byte address 0x800
    localparam int DATA_WORDS = 512;
    localparam int WATCHDOG_CYCLES = 40 * PROG_WORDS + 4 * (PROG_WORDS + 2 * DATA_WORDS) + 200;
    localparam word_t NOP = {OP_RTYPE, 15'd0, 5'd0, FN_OR}; // or r0, r0, r0

    logic      clk;
    logic      rst;
    logic      run;
    logic      host_req;
    logic      host_we;
    word_t     host_addr;
    word_t     host_wdata;
    word_t     host_rdata;
    logic      host_ack;
    logic      wb_valid;
    reg_addr_t wb_reg;
    word_t     wb_data;
    logic      halted;

    integer    seed;
    word_t     model_mem [MEM_WORDS];  // Initial image and later the ISS result
    word_t     model_regs [32];
    logic      jump_slot [N_SLOTS];
    reg_addr_t exp_reg [$];            // Expected retire trace
    word_t     exp_data [$];

    cpu_top #(.MEM_WORDS(MEM_WORDS)) uut (
        .clk(clk), .rst(rst), .run(run), .host_req(host_req), .host_we(host_we),
        .host_addr(host_addr), .host_wdata(host_wdata), .host_rdata(host_rdata),
        .host_ack(host_ack), .wb_valid(wb_valid), .wb_reg(wb_reg), .wb_data(wb_data),
        .halted(halted)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic end_in_failure();
        $display("TB FAILED");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic report_problem(string msg);
        $display("ERROR at %0t: %s", $time, msg);
        end_in_failure();
    endtask

    task automatic check_value(string name, word_t got, word_t exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
            end_in_failure();
        end
    endtask

    function automatic int pick(int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    // Spreads the whole word index over all 32 bits
    function automatic word_t fill_word(int i);
        return (word_t'(i) * 32'h9e37_79b1) ^ 32'h5a5a_c3c3;
    endfunction

    function automatic word_t rtype_word();
        logic [5:0] fn;
        reg_addr_t  rs;
        reg_addr_t  rt;
        reg_addr_t  rd;
        rs = 5'(pick(32));
        rt = 5'(pick(32));
        rd = 5'(pick(32)); // Sometimes r0 which must not retire
        case (pick(6))
            0: fn = FN_ADD;
            1: fn = FN_SUB;
            2: fn = FN_AND;
            3: fn = FN_OR;
            4: fn = FN_SLT;
            default: fn = FN_MUL;
        endcase
        return {OP_RTYPE, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic word_t slot_word();
        reg_addr_t   rs;
        reg_addr_t   rt;
        logic [15:0] imm;
        rs  = 5'(pick(32));
        rt  = 5'(pick(32));
        imm = 16'(pick(65536));
        case (pick(10))
            0, 1, 2: return rtype_word();
            3: return {OP_ADDI, rs, rt, imm};
            4: return {OP_ORI, rs, rt, imm};
            5: return {OP_LUI, 5'd0, rt, imm};
            6: return {OP_LDW, 5'd0, rt, 16'(2048 + 4 * pick(512))}; // Base r0 into 0x800..0xffc
            7: return {OP_LDB, 5'd0, rt, 16'(2048 + pick(2048))};
            8: return {OP_STW, 5'd0, rt, 16'(2048 + 4 * pick(512))};
            default: return {OP_STB, 5'd0, rt, 16'(2048 + pick(2048))};
        endcase
    endfunction

    task automatic build_program();
        int t;
        for (int i = 0; i < MEM_WORDS; i++) begin
            model_mem[i] = (i >= DATA_BASE) ? fill_word(i) : NOP;
        end
        // Last slot never jumps so every jump finds a target
        for (int s = 0; s < N_SLOTS; s++) begin
            jump_slot[s] = (s < N_SLOTS - 1) && (pick(8) == 0);
        end
        for (int s = 0; s < N_SLOTS; s++) begin
            if (jump_slot[s]) begin
                t = s + 1 + pick(N_SLOTS - 1 - s);
                while (jump_slot[t]) t++;
                // Lands behind the target's instruction so that one is skipped
                model_mem[4 * s]     = {OP_JUMP, 26'(4 * t + 1)};
                model_mem[4 * s + 1] = rtype_word(); // Delay slot does real work
            end else begin
                model_mem[4 * s] = slot_word();
            end
        end
        model_mem[4 * N_SLOTS] = {OP_HALT, 26'd0};
    endtask

    function automatic word_t alu_result(logic [5:0] fn, word_t a, word_t b);
        case (fn)
            FN_ADD:  return a + b;
            FN_SUB:  return a - b;
            FN_AND:  return a & b;
            FN_OR:   return a | b;
            FN_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            FN_MUL:  return a * b;
            default: return 'x;
        endcase
    endfunction

    task automatic model_write(reg_addr_t r, word_t v);
        if (r != '0) begin
            model_regs[r] = v;
            exp_reg.push_back(r);
            exp_data.push_back(v);
        end
    endtask

    // ISS with one delay slot after jump and halt
    task automatic run_model();
        word_t       pc;
        word_t       npc;
        word_t       nxt;
        word_t       ins;
        word_t       a;
        word_t       b;
        word_t       addr;
        logic [15:0] imm;
        logic        halting;
        logic        stop;
        for (int i = 0; i < 32; i++) model_regs[i] = '0;
        pc      = '0;
        npc     = 32'd4;
        halting = 1'b0;
        stop    = 1'b0;
        for (int step = 0; step < 2 * PROG_WORDS && !stop; step++) begin
            ins  = model_mem[pc[11:2]];
            imm  = ins[15:0];
            a    = model_regs[ins[25:21]];
            b    = model_regs[ins[20:16]];
            addr = a + {{16{imm[15]}}, imm};
            stop = halting; // This one is the halt's delay slot
            nxt  = npc + 32'd4;
            case (ins[31:26])
                OP_RTYPE: model_write(ins[15:11], alu_result(ins[5:0], a, b));
                OP_ADDI:  model_write(ins[20:16], addr);
                OP_ORI:   model_write(ins[20:16], a | {16'h0000, imm});
                OP_LUI:   model_write(ins[20:16], {imm, 16'h0000});
                OP_LDW:   model_write(ins[20:16], model_mem[addr[11:2]]);
                OP_LDB:   model_write(ins[20:16], {24'h0, model_mem[addr[11:2]][8 * addr[1:0] +: 8]});
                OP_STW:   model_mem[addr[11:2]] = b;
                OP_STB:   model_mem[addr[11:2]][8 * addr[1:0] +: 8] = b[7:0];
                OP_JUMP:  nxt = {pc[31:28], ins[25:0], 2'b00};
                OP_HALT:  halting = 1'b1;
                default:  report_problem("model met an unknown opcode");
            endcase
            pc  = npc;
            npc = nxt;
        end
        if (!stop) report_problem("model never reached the halt instruction");
    endtask

    // Starts and ends on a falling edge
    task automatic host_access(logic we, int idx, word_t wdata, output word_t rdata);
        int waited;
        host_req   = 1'b1;
        host_we    = we;
        host_addr  = word_t'(idx);
        host_wdata = wdata;
        @(negedge clk);
        host_req = 1'b0;
        waited   = 0;
        while (!host_ack) begin
            if (waited == 8) report_problem("host port never acknowledged the request");
            @(negedge clk);
            waited++;
        end
        rdata = host_rdata;
    endtask

    task automatic check_idle_outputs();
        check_value("wb_valid", 32'(wb_valid), 32'd0);
        check_value("halted", 32'(halted), 32'd0);
        check_value("host_ack", 32'(host_ack), 32'd0);
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        report_problem("watchdog expired before the run finished");
    end

    initial begin
        word_t rdata;
        int    idx;
        seed       = 32'h322b;
        clk        = 1'b0;
        rst        = 1'b1;
        run        = 1'b0;
        host_req   = 1'b0;
        host_we    = 1'b0;
        host_addr  = '0;
        host_wdata = '0;
        build_program();

        repeat (4) begin
            @(negedge clk);
            check_idle_outputs();
        end
        rst = 1'b0;
        repeat (2) begin
            @(negedge clk);
            check_idle_outputs();
        end

        // Program and data region go in through the host port
        for (int i = 0; i < PROG_WORDS; i++) host_access(1'b1, i, model_mem[i], rdata);
        for (int i = DATA_BASE; i < DATA_BASE + DATA_WORDS; i++) begin
            host_access(1'b1, i, model_mem[i], rdata);
        end
        check_value("wb_valid", 32'(wb_valid), 32'd0);
        check_value("halted", 32'(halted), 32'd0);
        run_model();

        run = 1'b1;
        idx = 0;
        while (!halted) begin
            @(negedge clk);
            if (wb_valid) begin
                if (idx >= exp_reg.size()) report_problem("writeback past the end of the trace");
                check_value("wb_reg", 32'(wb_reg), 32'(exp_reg[idx]));
                check_value("wb_data", wb_data, exp_data[idx]);
                idx++;
            end
        end
        check_value("retired writebacks", 32'(idx), 32'(exp_reg.size()));
        repeat (10) begin
            @(negedge clk);
            check_value("halted", 32'(halted), 32'd1);  // Sticky
            check_value("wb_valid", 32'(wb_valid), 32'd0);
        end

        run = 1'b0;
        for (int i = DATA_BASE; i < DATA_BASE + DATA_WORDS; i++) begin
            host_access(1'b0, i, 32'd0, rdata);
            check_value($sformatf("mem[%0d]", i), rdata, model_mem[i]);
        end

        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- cpu_top.f
cpu_pkg.sv
fetch_unit.sv
decode_control.sv
decode_stage.sv
register_file.sv
execute_stage.sv
mem_stage.sv
mem_arbiter.sv
unified_mem.sv
cpu_top.sv
cpu_assert.sv
cpu_tb.sv

//--- Makefile
VERILATOR ?= verilator
FILELIST  ?= cpu_top.f
TB_TOP    ?= cpu_tb
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(OBJ_DIR) -o V$(TB_TOP)
	./$(OBJ_DIR)/V$(TB_TOP)

clean:
	rm -rf $(OBJ_DIR)
